// File: sim.f
+incdir+verilog
verilog/dbus_pkg.sv
verilog/sram_pkg.sv
verilog/ram_if.sv
verilog/dbus_decode.sv
verilog/bytes_conv.sv
verilog/sram_ctrl.sv
verilog/ticker.sv
verilog/dbus_top.sv
bench/tb_clk.sv
bench/sram_model.sv
bench/tb_dbus.sv

// File: Makefile
SIM := obj_dir/Vtb_dbus
SRCS := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) sim.f
	verilator --binary --timing -Wno-fatal --top-module tb_dbus -f sim.f

run: $(SIM)
	$(SIM) > sim.log
	cat sim.log
	! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_dbus.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module tb_dbus;

    localparam int PERIOD    = 100;
    localparam int POOL      = 8;    // pool indexes are drawn from three random bits
    localparam int RT_OPS    = 32;
    localparam int SW_OPS    = 24;
    localparam int IRQ_WAIT  = 40;
    localparam int TOTAL_OPS = POOL + RT_OPS + 4 + 2 * SW_OPS + 2 + 9 + POOL + 5;
    localparam int LIMIT_NS  = (TOTAL_OPS * 8 + 100) * PERIOD;

    logic        clk;
    logic        rst_n;
    logic [31:0] bus_addr;
    logic [3:0]  bus_be;
    logic        bus_rd;
    logic        bus_wr;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        bus_stall;
    logic        irq;
    logic [19:0] base_addr;
    logic        base_ce_n;
    logic        base_oe_n;
    logic        base_we_n;
    logic [31:0] base_data;
    logic [19:0] ext_addr;
    logic        ext_ce_n;
    logic        ext_oe_n;
    logic        ext_we_n;
    logic [31:0] ext_data;
    logic [31:0] ram_wdata;
    logic        ram_oe;

    logic [31:0] ref_mem [logic [20:0]];    // keyed by {chip, word}
    logic [20:0] pool_key [POOL];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       name_q [$];
    int          errors;
    int          ce_cycles [2];

    tb_clk #(.PERIOD(PERIOD), .RESET_CYCLES(3)) clkgen (.clk_o(clk), .rst_n_o(rst_n));

    dbus_top DUT (
        .clk (clk), .rst_n_i (rst_n),
        .master_address_i (bus_addr), .master_byteenable_i (bus_be),
        .master_read_i (bus_rd), .master_write_i (bus_wr), .master_wrdata_i (bus_wdata),
        .master_rddata_o (bus_rdata), .master_stall_o (bus_stall), .tick_irq_o (irq),
        .base_ram_addr_o (base_addr), .base_ram_ce_n_o (base_ce_n),
        .base_ram_oe_n_o (base_oe_n), .base_ram_we_n_o (base_we_n),
        .base_ram_data_i (base_data),
        .ext_ram_addr_o (ext_addr), .ext_ram_ce_n_o (ext_ce_n),
        .ext_ram_oe_n_o (ext_oe_n), .ext_ram_we_n_o (ext_we_n),
        .ext_ram_data_i (ext_data),
        .ram_data_o (ram_wdata), .ram_data_oe_o (ram_oe)
    );

    sram_model base_ram (.addr_i(base_addr), .ce_n_i(base_ce_n), .oe_n_i(base_oe_n),
        .we_n_i(base_we_n), .data_i(ram_wdata), .data_oe_i(ram_oe), .data_o(base_data));
    sram_model ext_ram (.addr_i(ext_addr), .ce_n_i(ext_ce_n), .oe_n_i(ext_oe_n),
        .we_n_i(ext_we_n), .data_i(ram_wdata), .data_oe_i(ram_oe), .data_o(ext_data));

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (new_word & mask) | (old_word & ~mask);
    endfunction

    function automatic logic [31:0] ram_address(input logic [20:0] key);
        return {`RAM_REGION, 5'd0, key, 2'b00};
    endfunction

    function automatic logic [31:0] tick_address(input logic [5:0] reg_idx);
        return {`IO_REGION, 12'd0, `TICKER_DEV, reg_idx, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %08h, actual %08h", name, expected, actual);
            errors++;
        end
    endtask

    // holds one request until stall is seen low between edges
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        bus_addr  <= addr;
        bus_be    <= be;
        bus_rd    <= !wr;
        bus_wr    <= wr;
        bus_wdata <= wdata;
        @(negedge clk);
        while (bus_stall)
            @(negedge clk);
        rdata = bus_rdata;
        @(posedge clk);
        bus_rd <= 1'b0;
        bus_wr <= 1'b0;
    endtask

    task automatic ram_write(input logic [20:0] key, input logic [3:0] be,
                             input logic [31:0] data);
        logic [31:0] old_word;
        logic [31:0] unused;
        old_word = ref_mem.exists(key) ? ref_mem[key] : '0;
        bus_access(1'b1, ram_address(key), be, data, unused);
        ref_mem[key] = merge_bytes(old_word, data, be);
    endtask

    task automatic expect_read(input string name, input logic [31:0] addr,
                               input logic [31:0] expected);
        logic [31:0] data;
        exp_q.push_back(expected);
        name_q.push_back(name);
        bus_access(1'b0, addr, 4'hf, '0, data);
        act_q.push_back(data);
    endtask

    task automatic ram_read(input string name, input logic [20:0] key);
        expect_read(name, ram_address(key), ref_mem[key]);
    endtask

    always @(negedge clk) begin
        while (act_q.size() > 0 && exp_q.size() > 0)
            check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end

    // only the chip named by address bit 22 may be enabled
    always @(negedge clk) begin
        if (!base_ce_n)
            ce_cycles[0]++;
        if (!ext_ce_n)
            ce_cycles[1]++;
        if (!base_ce_n && !ext_ce_n) begin
            $display("ERROR: both chip enables are low at %0t", $time);
            errors++;
        end else if ((!base_ce_n && bus_addr[`CHIP_SEL_BIT]) ||
                     (!ext_ce_n && !bus_addr[`CHIP_SEL_BIT])) begin
            $display("ERROR: chip enable does not match address bit 22 at %0t", $time);
            errors++;
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("ERROR: timeout, run still busy after %0d ns with %0d errors", LIMIT_NS, errors);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] data;
        logic [31:0] first;
        logic [31:0] addr;
        logic [20:0] key;
        int          c0;
        int          c1;
        int          waited;
        void'($urandom(46695));
        errors    = 0;
        bus_addr  = '0;
        bus_be    = '0;
        bus_rd    = 1'b0;
        bus_wr    = 1'b0;
        bus_wdata = '0;
        wait (rst_n);
        @(negedge clk);
        check_value("reset state", 32'h0fc,
            32'({bus_stall, base_ce_n, ext_ce_n, base_oe_n, ext_oe_n, base_we_n, ext_we_n,
                 ram_oe, irq}));

        for (int i = 0; i < POOL; i++) begin
            rnd = $urandom;
            pool_key[i] = {i[0], rnd[19:0]};    // alternate chips across the pool
            ram_write(pool_key[i], 4'hf, $urandom);
        end

        for (int i = 0; i < RT_OPS; i++) begin
            rnd = $urandom;
            if (rnd[31])
                ram_write(pool_key[rnd[2:0]], 4'hf, $urandom);
            else
                ram_read("full-word round trip", pool_key[rnd[2:0]]);
        end

        data = $urandom;
        c0 = ce_cycles[0];
        c1 = ce_cycles[1];
        ram_write({1'b0, pool_key[0][19:0]}, 4'hf, data);
        check_value("base chip enable on base write", c0 + 1, ce_cycles[0]);
        check_value("ext chip enable on base write", c1, ce_cycles[1]);
        ram_write({1'b1, pool_key[0][19:0]}, 4'hf, ~data);
        check_value("ext chip enable on ext write", c1 + 1, ce_cycles[1]);
        ram_read("chip select base word", {1'b0, pool_key[0][19:0]});
        ram_read("chip select ext word", {1'b1, pool_key[0][19:0]});

        for (int i = 0; i < SW_OPS; i++) begin
            rnd = $urandom;
            key = pool_key[rnd[2:0]];
            ram_write(key, rnd[7:4], $urandom);
            ram_read("sub-word write", key);
        end
        ram_write(pool_key[1], 4'h0, ~ref_mem[pool_key[1]]);
        ram_read("write with no enables", pool_key[1]);

        // unmapped copies of pool addresses must leave ram alone
        for (int i = 0; i < 4; i++) begin
            rnd = $urandom;
            addr = ram_address(pool_key[i]);
            addr[31:28] = rnd[31:28];
            if (addr[31:28] == `RAM_REGION || addr[31:28] == `IO_REGION)
                addr[28] = ~addr[28];
            bus_access(1'b1, addr, 4'hf, $urandom, data);
            expect_read("unmapped read", addr, 32'h0);
        end
        expect_read("unmapped io device", {`IO_REGION, 12'd0, 8'd5, 6'd0, 2'b00}, 32'h0);
        for (int i = 0; i < POOL; i++)
            ram_read("ram after unmapped writes", pool_key[i]);

        bus_access(1'b0, tick_address(`TICK_COUNT), 4'hf, '0, first);
        bus_access(1'b0, tick_address(`TICK_COUNT), 4'hf, '0, data);
        if (data < first) begin
            $display("ERROR: ticker count went backwards from %0d to %0d", first, data);
            errors++;
        end
        bus_access(1'b1, tick_address(`TICK_COMPARE), 4'hf, data + 20, first);
        expect_read("ticker compare readback", tick_address(`TICK_COMPARE), data + 20);
        waited = 0;
        while (!irq && waited < IRQ_WAIT) begin
            @(negedge clk);
            waited++;
        end
        check_value("ticker interrupt raised", 32'h1, 32'(irq));
        bus_access(1'b1, tick_address(`TICK_COMPARE), 4'hf, '0, data);
        @(negedge clk);
        check_value("ticker interrupt cleared", 32'h0, 32'(irq));

        repeat (2) @(negedge clk);
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: bench/sram_model.sv
`timescale 1ns/10ps

// asynchronous 32-bit SRAM whose reads follow ce and oe and whose writes land mid pulse
module sram_model #(
    parameter int AW = 20
) (
    input  logic [AW-1:0] addr_i,
    input  logic          ce_n_i,
    input  logic          oe_n_i,
    input  logic          we_n_i,
    input  logic [31:0]   data_i,
    input  logic          data_oe_i,
    output logic [31:0]   data_o
);

    logic [31:0] mem [0:(1 << AW)-1];

    initial begin
        for (int i = 0; i < (1 << AW); i++)
            mem[i] = {i[19:8] ^ 12'ha5c, i[19:0]};    // every word starts with its own value
    end

    // sample well inside the write pulse so the strobes have settled
    always @(negedge we_n_i) begin
        #10;
        if (!ce_n_i && !we_n_i && data_oe_i)
            mem[addr_i] = data_i;
    end

    assign data_o = (!ce_n_i && !oe_n_i) ? mem[addr_i] : '0;

endmodule

// File: bench/tb_clk.sv
`timescale 1ns/10ps

module tb_clk #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: verilog/dbus_top.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module dbus_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [`ADDR_W-1:0]      master_address_i,
    input  logic [3:0]              master_byteenable_i,
    input  logic                    master_read_i,
    input  logic                    master_write_i,
    input  logic [`DATA_W-1:0]      master_wrdata_i,
    output logic [`DATA_W-1:0]      master_rddata_o,
    output logic                    master_stall_o,
    output logic                    tick_irq_o,
    output logic [`RAM_WORD_AW-1:0] base_ram_addr_o,
    output logic                    base_ram_ce_n_o,
    output logic                    base_ram_oe_n_o,
    output logic                    base_ram_we_n_o,
    input  logic [`DATA_W-1:0]      base_ram_data_i,
    output logic [`RAM_WORD_AW-1:0] ext_ram_addr_o,
    output logic                    ext_ram_ce_n_o,
    output logic                    ext_ram_oe_n_o,
    output logic                    ext_ram_we_n_o,
    input  logic [`DATA_W-1:0]      ext_ram_data_i,
    output logic [`DATA_W-1:0]      ram_data_o,
    output logic                    ram_data_oe_o
);

    logic                tick_read;
    logic                tick_write;
    dbus_pkg::bus_addr_u tick_reg;
    logic [`DATA_W-1:0]  tick_wrdata;
    logic [`DATA_W-1:0]  tick_rddata;

    ram_if up ();      // decoder to byte converter
    ram_if down ();    // byte converter to SRAM controller

    dbus_decode dbus0 (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_rddata_o     (master_rddata_o),
        .master_stall_o      (master_stall_o),
        .up                  (up),
        .tick_read_o         (tick_read),
        .tick_write_o        (tick_write),
        .tick_reg_o          (tick_reg),
        .tick_wrdata_o       (tick_wrdata),
        .tick_rddata_i       (tick_rddata)
    );

    bytes_conv mem_conv (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .up      (up),
        .down    (down)
    );

    sram_ctrl sram0 (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .down            (down),
        .base_ram_addr_o (base_ram_addr_o),
        .base_ram_ce_n_o (base_ram_ce_n_o),
        .base_ram_oe_n_o (base_ram_oe_n_o),
        .base_ram_we_n_o (base_ram_we_n_o),
        .base_ram_data_i (base_ram_data_i),
        .ext_ram_addr_o  (ext_ram_addr_o),
        .ext_ram_ce_n_o  (ext_ram_ce_n_o),
        .ext_ram_oe_n_o  (ext_ram_oe_n_o),
        .ext_ram_we_n_o  (ext_ram_we_n_o),
        .ext_ram_data_i  (ext_ram_data_i),
        .ram_data_o      (ram_data_o),
        .ram_data_oe_o   (ram_data_oe_o)
    );

    ticker ticker_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .tick_read_i   (tick_read),
        .tick_write_i  (tick_write),
        .tick_reg_i    (tick_reg),
        .tick_wrdata_i (tick_wrdata),
        .tick_rddata_o (tick_rddata),
        .tick_irq_o    (tick_irq_o)
    );

endmodule

// File: verilog/ticker.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module ticker (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                tick_read_i,
    input  logic                tick_write_i,
    input  dbus_pkg::bus_addr_u tick_reg_i,
    input  logic [`DATA_W-1:0]  tick_wrdata_i,
    output logic [`DATA_W-1:0]  tick_rddata_o,
    output logic                tick_irq_o
);

    logic [`DATA_W-1:0] count_q;
    logic [`DATA_W-1:0] compare_q;
    logic               wr_count;
    logic               wr_compare;

    assign wr_count   = tick_write_i && (tick_reg_i.io.reg_idx == `TICK_COUNT);
    assign wr_compare = tick_write_i && (tick_reg_i.io.reg_idx == `TICK_COMPARE);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q    <= '0;
            compare_q  <= '0;
            tick_irq_o <= 1'b0;
        end else begin
            count_q <= wr_count ? tick_wrdata_i : count_q + 1'b1;
            if (wr_compare)
                compare_q <= tick_wrdata_i;
            // writing compare acknowledges the interrupt
            if (wr_compare)
                tick_irq_o <= 1'b0;
            else if (compare_q != '0 && count_q == compare_q)
                tick_irq_o <= 1'b1;
        end
    end

    always_comb begin
        tick_rddata_o = '0;
        if (tick_read_i) begin
            case (tick_reg_i.io.reg_idx)
                `TICK_COUNT:   tick_rddata_o = count_q;
                `TICK_COMPARE: tick_rddata_o = compare_q;
                default:       tick_rddata_o = '0;
            endcase
        end
    end

endmodule

// File: verilog/sram_ctrl.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module sram_ctrl (
    input  logic                    clk,
    input  logic                    rst_n_i,
    ram_if.slave                    down,
    output logic [`RAM_WORD_AW-1:0] base_ram_addr_o,
    output logic                    base_ram_ce_n_o,
    output logic                    base_ram_oe_n_o,
    output logic                    base_ram_we_n_o,
    input  logic [`DATA_W-1:0]      base_ram_data_i,
    output logic [`RAM_WORD_AW-1:0] ext_ram_addr_o,
    output logic                    ext_ram_ce_n_o,
    output logic                    ext_ram_oe_n_o,
    output logic                    ext_ram_we_n_o,
    input  logic [`DATA_W-1:0]      ext_ram_data_i,
    output logic [`DATA_W-1:0]      ram_data_o,
    output logic                    ram_data_oe_o
);

    sram_pkg::sram_state_e state_q;
    sram_pkg::sram_state_e state_d;
    logic                  req;
    logic                  active;
    logic [`DATA_W-1:0]    chip_data;
    logic [`DATA_W-1:0]    rddata_q;

    // a write is only taken as a whole word
    assign req    = down.read || (down.write && (&down.byteenable));
    assign active = (state_q == sram_pkg::ACCESS);

    always_comb begin
        state_d = state_q;
        case (state_q)
            sram_pkg::IDLE:   if (req) state_d = sram_pkg::ACCESS;
            sram_pkg::ACCESS: state_d = sram_pkg::DONE;
            default:          state_d = sram_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            state_q <= sram_pkg::IDLE;
        else
            state_q <= state_d;
    end

    // address is already steady in the IDLE cycle, strobes follow in ACCESS
    assign base_ram_addr_o = down.cmd.word;
    assign ext_ram_addr_o  = down.cmd.word;
    assign base_ram_ce_n_o = ~(active && !down.cmd.chip);
    assign ext_ram_ce_n_o  = ~(active && down.cmd.chip);
    assign base_ram_oe_n_o = ~(active && !down.cmd.we);
    assign ext_ram_oe_n_o  = ~(active && !down.cmd.we);
    assign base_ram_we_n_o = ~(active && down.cmd.we);
    assign ext_ram_we_n_o  = ~(active && down.cmd.we);

    assign ram_data_o    = down.wrdata;
    assign ram_data_oe_o = active && down.cmd.we;

    assign chip_data = down.cmd.chip ? ext_ram_data_i : base_ram_data_i;

    always_ff @(posedge clk) begin
        if (active && !down.cmd.we)
            rddata_q <= chip_data;
    end

    assign down.rddata = rddata_q;
    assign down.stall  = ((state_q == sram_pkg::IDLE) && req) || active;

endmodule

// File: verilog/bytes_conv.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module bytes_conv (
    input  logic  clk,
    input  logic  rst_n_i,
    ram_if.slave  up,
    ram_if.master down
);

    typedef enum logic [1:0] {
        PASS,
        FETCH,
        STORE
    } conv_state_e;

    conv_state_e        state_q;
    conv_state_e        state_d;
    logic [`DATA_W-1:0] merge_q;
    logic [`DATA_W-1:0] merged;
    logic               full_wr;
    logic               empty_wr;
    logic               part_wr;

    assign full_wr  = up.write && (&up.byteenable);
    assign empty_wr = up.write && (up.byteenable == '0);
    assign part_wr  = up.write && !full_wr && !empty_wr;

    // enabled bytes of the master data laid over the fetched word
    always_comb begin
        merged = down.rddata;
        for (int i = 0; i < 4; i++) begin
            if (up.byteenable[i])
                merged[8*i +: 8] = up.wrdata[8*i +: 8];
        end
    end

    always_comb begin
        state_d     = state_q;
        down.read   = 1'b0;
        down.write  = 1'b0;
        down.cmd    = up.cmd;
        down.wrdata = up.wrdata;
        up.stall    = 1'b0;
        case (state_q)
            PASS: begin
                if (part_wr) begin
                    up.stall = 1'b1;
                    state_d  = FETCH;
                end else begin
                    // a write with no enables finishes here untouched
                    down.read  = up.read;
                    down.write = full_wr;
                    up.stall   = down.stall && (up.read || full_wr);
                end
            end
            FETCH: begin
                down.read   = 1'b1;
                down.cmd.we = 1'b0;
                up.stall    = 1'b1;
                if (!down.stall)
                    state_d = STORE;
            end
            default: begin
                down.write  = 1'b1;
                down.cmd.we = 1'b1;
                down.wrdata = merge_q;
                up.stall    = down.stall;    // master is released with the store
                if (!down.stall)
                    state_d = PASS;
            end
        endcase
    end

    assign down.byteenable = '1;    // the SRAM side only moves whole words
    assign up.rddata       = down.rddata;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            state_q <= PASS;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk) begin
        if (state_q == FETCH && !down.stall)
            merge_q <= merged;
    end

endmodule

// File: verilog/dbus_decode.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

module dbus_decode (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [`ADDR_W-1:0]   master_address_i,
    input  dbus_pkg::byte_en_t   master_byteenable_i,
    input  logic                 master_read_i,
    input  logic                 master_write_i,
    input  logic [`DATA_W-1:0]   master_wrdata_i,
    output logic [`DATA_W-1:0]   master_rddata_o,
    output logic                 master_stall_o,
    ram_if.master                up,
    output logic                 tick_read_o,
    output logic                 tick_write_o,
    output dbus_pkg::bus_addr_u  tick_reg_o,
    output logic [`DATA_W-1:0]   tick_wrdata_o,
    input  logic [`DATA_W-1:0]   tick_rddata_i
);

    dbus_pkg::bus_addr_u addr;
    dbus_pkg::target_e   target;
    dbus_pkg::target_e   target_q;
    dbus_pkg::target_e   target_sel;
    logic                held_q;
    logic                ram_busy;

    assign addr = master_address_i;

    always_comb begin
        if (addr.ram.region == `RAM_REGION) begin
            target = dbus_pkg::RAM;
        end else if (addr.io.region == `IO_REGION && addr.io.device == `TICKER_DEV) begin
            target = dbus_pkg::TICKER;
        end else begin
            target = dbus_pkg::NONE;
        end
    end

    // while a ram access is stalled the target comes from the first cycle
    assign target_sel = held_q ? target_q : target;
    assign ram_busy = (target_sel == dbus_pkg::RAM) && (master_read_i || master_write_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held_q   <= 1'b0;
            target_q <= dbus_pkg::NONE;
        end else begin
            held_q <= ram_busy && up.stall;
            if (!held_q)
                target_q <= target;
        end
    end

    assign up.read       = master_read_i && (target_sel == dbus_pkg::RAM);
    assign up.write      = master_write_i && (target_sel == dbus_pkg::RAM);
    assign up.byteenable = master_byteenable_i;
    assign up.cmd.chip   = addr.ram.chip;
    assign up.cmd.word   = addr.ram.word;
    assign up.cmd.we     = master_write_i;
    assign up.wrdata     = master_wrdata_i;

    assign tick_read_o   = master_read_i && (target_sel == dbus_pkg::TICKER);
    assign tick_write_o  = master_write_i && (target_sel == dbus_pkg::TICKER);
    assign tick_reg_o    = addr;
    assign tick_wrdata_o = master_wrdata_i;

    always_comb begin
        case (target_sel)
            dbus_pkg::RAM:    master_rddata_o = up.rddata;
            dbus_pkg::TICKER: master_rddata_o = tick_rddata_i;
            default:          master_rddata_o = '0;    // unmapped reads give zero
        endcase
    end

    // only the ram path ever holds the master
    assign master_stall_o = ram_busy && up.stall;

endmodule

// File: verilog/ram_if.sv
`timescale 1ns/10ps
`include "soc_defs.svh"

// word request link where the master holds everything steady while stall is high
interface ram_if;

    logic                 read;
    logic                 write;
    dbus_pkg::byte_en_t   byteenable;
    sram_pkg::ram_cmd_t   cmd;
    logic [`DATA_W-1:0]   wrdata;
    logic [`DATA_W-1:0]   rddata;     // valid in the cycle stall is low
    logic                 stall;

    modport master (
        output read,
        output write,
        output byteenable,
        output cmd,
        output wrdata,
        input  rddata,
        input  stall
    );

    modport slave (
        input  read,
        input  write,
        input  byteenable,
        input  cmd,
        input  wrdata,
        output rddata,
        output stall
    );

endinterface

// File: verilog/sram_pkg.sv
`include "soc_defs.svh"

package sram_pkg;

    // one whole-word request as seen by the SRAM side
    typedef struct packed {
        logic                    chip;    // 1 picks the ext chip
        logic [`RAM_WORD_AW-1:0] word;
        logic                    we;      // the word is written, not read
    } ram_cmd_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } sram_state_e;

endpackage

// File: verilog/dbus_pkg.sv
`include "soc_defs.svh"

package dbus_pkg;

    // in the ram region the chip bit sits right above the word index
    typedef struct packed {
        logic [`REGION_W-1:0]                     region;
        logic [`ADDR_W-`REGION_W-`CHIP_SEL_BIT-2:0] unused;
        logic                                     chip;
        logic [`RAM_WORD_AW-1:0]                  word;
        logic [1:0]                               offset;
    } ram_addr_t;

    typedef struct packed {
        logic [`REGION_W-1:0] region;
        logic [11:0]          unused;
        logic [7:0]           device;
        logic [5:0]           reg_idx;
        logic [1:0]           offset;
    } io_addr_t;

    // one bus address seen either as a ram word or as a device register
    typedef union packed {
        ram_addr_t ram;
        io_addr_t  io;
    } bus_addr_u;

    typedef logic [3:0] byte_en_t;

    typedef enum logic [1:0] {
        RAM,
        TICKER,
        NONE
    } target_e;

endpackage

// File: verilog/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

`define ADDR_W        32
`define DATA_W        32
`define REGION_W      4

// top address nibble of each region
`define RAM_REGION    4'd8
`define IO_REGION     4'd11

`define RAM_WORD_AW   20
`define CHIP_SEL_BIT  22    // set selects the ext chip

`define TICKER_DEV    8'd0

// ticker register indexes
`define TICK_COUNT    6'd0
`define TICK_COMPARE  6'd1

`endif
